// ==== hdl/spill_pkg.sv ====
`default_nettype none

package spill_pkg;

   // chunk geometry
   localparam int TASKS_PER_CHUNK = 4;
   localparam int SLOT_W = $clog2(TASKS_PER_CHUNK);
   localparam int NUM_CHUNKS = 8;
   localparam int CHUNK_ID_W = 3;

   // spill memory map, one slot per word
   localparam int ADDR_W = 6;
   localparam int MEM_DEPTH = 64;
   localparam logic [ADDR_W-1:0] ADDR_CHUNK_BASE = 6'd0;  // chunk id * 4 + slot
   localparam logic [ADDR_W-1:0] ADDR_STACK_BASE = 6'd32; // free-chunk stack entries
   localparam logic [ADDR_W-1:0] ADDR_STACK_PTR = 6'd40;  // number of entries on the stack

   localparam int LOG_SPILL_DEPTH = 3;
   localparam int FLUSH_CYCLES = 15;  // idle cycles before a slot is padded
   localparam int FLUSH_W = $clog2(FLUSH_CYCLES + 1);
   localparam logic [3:0] TTYPE_SPLITTER = 4'hF;

   typedef logic [31:0] ts_t;
   typedef logic [CHUNK_ID_W:0] ptr_t;  // stack pointer, 0 to NUM_CHUNKS

   typedef struct packed {
      ts_t         ts;
      logic [15:0] object;
      logic [3:0]  ttype;
   } task_t;

   typedef struct packed {
      logic  valid;  // low for padding
      task_t tsk;
   } slot_t;

endpackage

`default_nettype wire

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  LOG_DEPTH = 2
) (
   input  logic     clk,
   input  logic     rstn,
   input  logic     wr_en,
   input  payload_t wr_data,
   input  logic     rd_en,
   output payload_t rd_data,
   output logic     full,
   output logic     empty
);

   payload_t mem [2**LOG_DEPTH];
   logic [LOG_DEPTH-1:0] wr_ptr;
   logic [LOG_DEPTH-1:0] rd_ptr;
   logic [LOG_DEPTH:0] count;
   logic do_wr;
   logic do_rd;

   assign full = count[LOG_DEPTH];  // count never exceeds the depth
   assign empty = (count == '0);
   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;
   assign rd_data = mem[rd_ptr];  // head word, no read cycle

   always_ff @(posedge clk) begin
      if (do_wr) mem[wr_ptr] <= wr_data;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         if (do_wr && !do_rd) count <= count + 1'b1;
         else if (do_rd && !do_wr) count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/coalescer.sv ====
`timescale 1ns/1ps
`default_nettype none

module coalescer import spill_pkg::*; (
   input  logic              clk,
   input  logic              rstn,
   input  logic              overflow_valid,
   output logic              overflow_ready,
   input  task_t             overflow_task,
   output logic              child_valid,
   input  logic              child_ready,
   output task_t             child_task,
   output logic              lock_coal,
   input  logic              lock_split,
   output logic              c_req,
   output logic              c_we,
   output logic [ADDR_W-1:0] c_addr,
   output slot_t             c_wdata,
   input  logic              c_gnt,
   input  logic              c_rvalid,
   input  slot_t             c_rdata,
   output ts_t               lvt
);

   typedef enum logic [3:0] {
      C_IDLE, C_GRAB, C_CHECK, C_RD_PTR, C_RD_PTR_W,
      C_RD_TOP, C_RD_TOP_W, C_WR_PTR, C_WR_SLOT, C_PUSH
   } coal_state_t;

   coal_state_t state;
   logic spill_full;
   logic spill_empty;
   logic spill_pop;
   task_t spill_head;
   logic child_full;
   logic child_empty;
   task_t child_new;
   ptr_t ptr;
   ptr_t ptr_dec;
   logic [CHUNK_ID_W-1:0] chunk_id;
   logic [SLOT_W-1:0] slot;
   logic last_slot;
   ts_t chunk_min;
   logic [FLUSH_W-1:0] idle_cnt;
   logic pad;

   assign overflow_ready = !spill_full;
   assign child_valid = !child_empty;
   assign ptr_dec = ptr - 1'b1;
   assign last_slot = (slot == SLOT_W'(TASKS_PER_CHUNK - 1));
   assign pad = spill_empty && (idle_cnt == FLUSH_W'(FLUSH_CYCLES));
   assign spill_pop = (state == C_WR_SLOT) && c_gnt && !spill_empty;

   // splitter task points back at the chunk
   assign child_new.ts = chunk_min;
   assign child_new.object = 16'(chunk_id);
   assign child_new.ttype = TTYPE_SPLITTER;

   sync_fifo #(
      .payload_t(task_t),
      .LOG_DEPTH(LOG_SPILL_DEPTH)
   ) spill_fifo (
      .clk(clk),
      .rstn(rstn),
      .wr_en(overflow_valid && overflow_ready),
      .wr_data(overflow_task),
      .rd_en(spill_pop),
      .rd_data(spill_head),
      .full(spill_full),
      .empty(spill_empty)
   );

   sync_fifo #(
      .payload_t(task_t),
      .LOG_DEPTH(2)  // 4 children
   ) child_fifo (
      .clk(clk),
      .rstn(rstn),
      .wr_en(state == C_PUSH),
      .wr_data(child_new),
      .rd_en(child_valid && child_ready),
      .rd_data(child_task),
      .full(child_full),
      .empty(child_empty)
   );

   always_comb begin
      c_req = 1'b0;
      c_we = 1'b0;
      c_addr = ADDR_STACK_PTR;
      c_wdata = '0;
      case (state)
         C_RD_PTR: c_req = 1'b1;
         C_RD_TOP: begin
            c_req = 1'b1;
            c_addr = ADDR_STACK_BASE + ADDR_W'(ptr_dec);  // top entry
         end
         C_WR_PTR: begin
            c_req = 1'b1;
            c_we = 1'b1;
            c_wdata.tsk.ts = ts_t'(ptr_dec);
         end
         C_WR_SLOT: begin
            c_req = !spill_empty || pad;
            c_we = 1'b1;
            c_addr = ADDR_CHUNK_BASE + ADDR_W'({chunk_id, slot});
            c_wdata.valid = !spill_empty;
            c_wdata.tsk = spill_empty ? '0 : spill_head;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= C_IDLE;
         lock_coal <= 1'b0;
      end else begin
         case (state)
            C_IDLE: if (!spill_empty && !child_full) state <= C_GRAB;
            C_GRAB: if (!lock_split) begin
               lock_coal <= 1'b1;
               state <= C_CHECK;
            end
            C_CHECK: begin
               lock_coal <= !lock_split;  // back off, splitter wins a tie
               state <= lock_split ? C_GRAB : C_RD_PTR;
            end
            C_RD_PTR: if (c_gnt) state <= C_RD_PTR_W;
            C_RD_PTR_W: if (c_rvalid) begin
               if (c_rdata.tsk.ts[CHUNK_ID_W:0] == '0) begin
                  // no free chunk, retry later
                  lock_coal <= 1'b0;
                  state <= C_IDLE;
               end else begin
                  state <= C_RD_TOP;
               end
            end
            C_RD_TOP: if (c_gnt) state <= C_RD_TOP_W;
            C_RD_TOP_W: if (c_rvalid) state <= C_WR_PTR;
            C_WR_PTR: if (c_gnt) begin
               lock_coal <= 1'b0;
               state <= C_WR_SLOT;
            end
            C_WR_SLOT: if (c_gnt && last_slot) state <= C_PUSH;
            C_PUSH: state <= C_IDLE;
            default: state <= C_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == C_RD_PTR_W && c_rvalid) ptr <= c_rdata.tsk.ts[CHUNK_ID_W:0];
      if (state == C_RD_TOP_W && c_rvalid) chunk_id <= c_rdata.tsk.ts[CHUNK_ID_W-1:0];
      if (state == C_WR_PTR) slot <= '0;
      else if (state == C_WR_SLOT && c_gnt) slot <= slot + 1'b1;
      // slot 0 always carries a task, so it seeds the minimum
      if (spill_pop && (slot == '0 || spill_head.ts < chunk_min)) chunk_min <= spill_head.ts;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         idle_cnt <= '0;
      end else if (state != C_WR_SLOT || !spill_empty || c_gnt) begin
         idle_cnt <= '0;
      end else if (!pad) begin
         idle_cnt <= idle_cnt + 1'b1;
      end
   end

   // conservative: only cleared once nothing is held anywhere
   always_ff @(posedge clk) begin
      if (!rstn) begin
         lvt <= '1;
      end else if (overflow_valid && overflow_ready) begin
         if (overflow_task.ts < lvt) lvt <= overflow_task.ts;
      end else if (spill_empty && child_empty && state == C_IDLE) begin
         lvt <= '1;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/splitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module splitter import spill_pkg::*; (
   input  logic              clk,
   input  logic              rstn,
   input  logic              split_valid,
   output logic              split_ready,
   input  task_t             split_task,
   output logic              out_valid,
   input  logic              out_ready,
   output task_t             out_task,
   output logic              lock_split,
   input  logic              lock_coal,
   output logic              s_req,
   output logic              s_we,
   output logic [ADDR_W-1:0] s_addr,
   output slot_t             s_wdata,
   input  logic              s_gnt,
   input  logic              s_rvalid,
   input  slot_t             s_rdata
);

   typedef enum logic [3:0] {
      S_GRAB, S_HOLD, S_INIT, S_IDLE, S_RD, S_RD_W, S_EMIT,
      S_RD_PTR, S_RD_PTR_W, S_WR_TOP, S_WR_PTR
   } split_state_t;

   split_state_t state;
   logic init_done;
   ptr_t cnt;
   ptr_t ptr;
   logic [CHUNK_ID_W-1:0] chunk;
   logic [SLOT_W-1:0] slot;
   logic last_slot;

   assign split_ready = (state == S_IDLE);
   assign out_valid = (state == S_EMIT);
   assign last_slot = (slot == SLOT_W'(TASKS_PER_CHUNK - 1));

   always_comb begin
      s_req = 1'b1;
      s_we = 1'b1;
      s_addr = ADDR_STACK_PTR;
      s_wdata = '0;
      s_wdata.valid = 1'b1;
      case (state)
         S_INIT: begin
            // entries 0..7 hold ids 0..7, then the pointer word gets 8
            if (cnt != ptr_t'(NUM_CHUNKS)) s_addr = ADDR_STACK_BASE + ADDR_W'(cnt);
            s_wdata.tsk.ts = ts_t'(cnt);
         end
         S_RD: begin
            s_we = 1'b0;
            s_addr = ADDR_CHUNK_BASE + ADDR_W'({chunk, slot});
         end
         S_RD_PTR: s_we = 1'b0;
         S_WR_TOP: begin
            s_addr = ADDR_STACK_BASE + ADDR_W'(ptr);
            s_wdata.tsk.ts = ts_t'(chunk);
         end
         S_WR_PTR: s_wdata.tsk.ts = ts_t'(ptr + 1'b1);
         default: begin
            s_req = 1'b0;
            s_we = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= S_GRAB;
         lock_split <= 1'b0;
         init_done <= 1'b0;
         cnt <= '0;
      end else begin
         case (state)
            S_GRAB: if (!lock_coal) begin
               lock_split <= 1'b1;
               state <= S_HOLD;
            end
            // never yields, wait for the coalescer to drop
            S_HOLD: if (!lock_coal) state <= init_done ? S_RD_PTR : S_INIT;
            S_INIT: if (s_gnt) begin
               cnt <= cnt + 1'b1;
               if (cnt == ptr_t'(NUM_CHUNKS)) begin
                  lock_split <= 1'b0;
                  init_done <= 1'b1;
                  state <= S_IDLE;
               end
            end
            S_IDLE: if (split_valid) state <= S_RD;
            S_RD: if (s_gnt) state <= S_RD_W;
            S_RD_W: if (s_rvalid) begin
               if (s_rdata.valid) state <= S_EMIT;
               else state <= last_slot ? S_GRAB : S_RD;  // skip padding
            end
            S_EMIT: if (out_ready) state <= last_slot ? S_GRAB : S_RD;
            S_RD_PTR: if (s_gnt) state <= S_RD_PTR_W;
            S_RD_PTR_W: if (s_rvalid) state <= S_WR_TOP;
            S_WR_TOP: if (s_gnt) state <= S_WR_PTR;
            S_WR_PTR: if (s_gnt) begin
               lock_split <= 1'b0;
               state <= S_IDLE;
            end
            default: state <= S_GRAB;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_IDLE) begin
         chunk <= split_task.object[CHUNK_ID_W-1:0];
         slot <= '0;
      end else if ((state == S_RD_W && s_rvalid && !s_rdata.valid) ||
                   (state == S_EMIT && out_ready)) begin
         slot <= slot + 1'b1;
      end
      if (state == S_RD_W && s_rvalid) out_task <= s_rdata.tsk;
      if (state == S_RD_PTR_W && s_rvalid) ptr <= s_rdata.tsk.ts[CHUNK_ID_W:0];
   end

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import spill_pkg::*; (
   input  logic              clk,
   input  logic              rstn,
   input  logic              c_req,
   input  logic              c_we,
   input  logic [ADDR_W-1:0] c_addr,
   input  slot_t             c_wdata,
   output logic              c_gnt,
   output logic              c_rvalid,
   output slot_t             c_rdata,
   input  logic              s_req,
   input  logic              s_we,
   input  logic [ADDR_W-1:0] s_addr,
   input  slot_t             s_wdata,
   output logic              s_gnt,
   output logic              s_rvalid,
   output slot_t             s_rdata,
   output logic              mem_en,
   output logic              mem_we,
   output logic [ADDR_W-1:0] mem_addr,
   output slot_t             mem_wdata,
   input  slot_t             mem_rdata
);

   logic last_s;   // splitter won the last grant
   logic rd_pend;  // a read was granted last cycle
   logic rd_own_s;

   assign c_gnt = c_req && (!s_req || last_s);
   assign s_gnt = s_req && !c_gnt;
   assign mem_en = c_gnt || s_gnt;
   assign mem_we = c_gnt ? c_we : s_we;
   assign mem_addr = c_gnt ? c_addr : s_addr;
   assign mem_wdata = c_gnt ? c_wdata : s_wdata;

   assign c_rvalid = rd_pend && !rd_own_s;
   assign s_rvalid = rd_pend && rd_own_s;
   assign c_rdata = mem_rdata;
   assign s_rdata = mem_rdata;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         last_s <= 1'b0;
         rd_pend <= 1'b0;
         rd_own_s <= 1'b0;
      end else begin
         if (mem_en) last_s <= s_gnt;
         rd_pend <= mem_en && !mem_we;
         rd_own_s <= s_gnt;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/spill_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module spill_mem import spill_pkg::*; (
   input  logic              clk,
   input  logic              mem_en,
   input  logic              mem_we,
   input  logic [ADDR_W-1:0] mem_addr,
   input  slot_t             mem_wdata,
   output slot_t             mem_rdata
);

   // chunk area, free stack and stack pointer share this array
   slot_t mem [MEM_DEPTH];

   always_ff @(posedge clk) begin
      if (mem_en) begin
         if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
         end else begin
            mem_rdata <= mem[mem_addr];  // valid one cycle later
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/spill_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module spill_top import spill_pkg::*; (
   input  logic  clk,
   input  logic  rstn,
   input  logic  overflow_valid,
   output logic  overflow_ready,
   input  task_t overflow_task,
   output logic  child_valid,
   input  logic  child_ready,
   output task_t child_task,
   input  logic  split_valid,
   output logic  split_ready,
   input  task_t split_task,
   output logic  out_valid,
   input  logic  out_ready,
   output task_t out_task,
   output ts_t   lvt
);

   logic lock_coal;
   logic lock_split;
   logic c_req;
   logic c_we;
   logic [ADDR_W-1:0] c_addr;
   slot_t c_wdata;
   logic c_gnt;
   logic c_rvalid;
   slot_t c_rdata;
   logic s_req;
   logic s_we;
   logic [ADDR_W-1:0] s_addr;
   slot_t s_wdata;
   logic s_gnt;
   logic s_rvalid;
   slot_t s_rdata;
   logic mem_en;
   logic mem_we;
   logic [ADDR_W-1:0] mem_addr;
   slot_t mem_wdata;
   slot_t mem_rdata;

   coalescer coal (
      .clk(clk),
      .rstn(rstn),
      .overflow_valid(overflow_valid),
      .overflow_ready(overflow_ready),
      .overflow_task(overflow_task),
      .child_valid(child_valid),
      .child_ready(child_ready),
      .child_task(child_task),
      .lock_coal(lock_coal),
      .lock_split(lock_split),
      .c_req(c_req),
      .c_we(c_we),
      .c_addr(c_addr),
      .c_wdata(c_wdata),
      .c_gnt(c_gnt),
      .c_rvalid(c_rvalid),
      .c_rdata(c_rdata),
      .lvt(lvt)
   );

   splitter split (
      .clk(clk),
      .rstn(rstn),
      .split_valid(split_valid),
      .split_ready(split_ready),
      .split_task(split_task),
      .out_valid(out_valid),
      .out_ready(out_ready),
      .out_task(out_task),
      .lock_split(lock_split),
      .lock_coal(lock_coal),
      .s_req(s_req),
      .s_we(s_we),
      .s_addr(s_addr),
      .s_wdata(s_wdata),
      .s_gnt(s_gnt),
      .s_rvalid(s_rvalid),
      .s_rdata(s_rdata)
   );

   // one memory port shared by both peers
   mem_arbiter arb (
      .clk(clk),
      .rstn(rstn),
      .c_req(c_req),
      .c_we(c_we),
      .c_addr(c_addr),
      .c_wdata(c_wdata),
      .c_gnt(c_gnt),
      .c_rvalid(c_rvalid),
      .c_rdata(c_rdata),
      .s_req(s_req),
      .s_we(s_we),
      .s_addr(s_addr),
      .s_wdata(s_wdata),
      .s_gnt(s_gnt),
      .s_rvalid(s_rvalid),
      .s_rdata(s_rdata),
      .mem_en(mem_en),
      .mem_we(mem_we),
      .mem_addr(mem_addr),
      .mem_wdata(mem_wdata),
      .mem_rdata(mem_rdata)
   );

   spill_mem mem (
      .clk(clk),
      .mem_en(mem_en),
      .mem_we(mem_we),
      .mem_addr(mem_addr),
      .mem_wdata(mem_wdata),
      .mem_rdata(mem_rdata)
   );

endmodule

`default_nettype wire

// ==== tb/tb_spill_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_spill_top import spill_pkg::*; ();

   localparam int WAIT_LIMIT = 5000;  // cycles per wait
   localparam int NUM_STIM = 90;

   logic clk = 1'b0;
   logic rstn;
   logic overflow_valid;
   logic overflow_ready;
   task_t overflow_task;
   logic child_valid;
   logic child_ready;
   task_t child_task;
   logic split_valid;
   logic split_ready;
   task_t split_task;
   logic out_valid;
   logic out_ready;
   task_t out_task;
   ts_t lvt;

   integer seed;
   task_t stim [NUM_STIM];
   int next_stim;
   task_t exp_out [$];  // in input order until popped at out_task
   ts_t exp_child [$];  // child timestamps in chunk order
   task_t held [$];     // children taken but not yet looped back
   task_t group [TASKS_PER_CHUNK];
   int group_n;
   logic hold_children;
   logic child_block;
   logic stall_child;
   logic stall_split;
   logic stall_out;
   string test_name;
   int test_errs;
   int errors;
   int checks;
   int tests_run;
   int tests_failed;

   spill_top DUT (.*);

   initial begin
      forever #5 clk = ~clk;
   end

   // expected child timestamp is the lowest ts of the first n tasks of a chunk
   function automatic ts_t chunk_min(input task_t grp [TASKS_PER_CHUNK], input int n);
      ts_t m;
      m = '1;
      for (int i = 0; i < n; i++) begin
         if (grp[i].ts < m) m = grp[i].ts;
      end
      return m;
   endfunction

   task automatic note_error();
      errors++;
      test_errs++;
   endtask

   task automatic report_value(input string what, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
      note_error();
   endtask

   task automatic abort_run(input string why);
      $display("ERROR: %s", why);
      $display("Simulation finished: FAIL");
      $finish;
   endtask

   // one cycle of a bounded wait
   task automatic tick(inout int n, input string what);
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) abort_run({"timeout, ", what});
   endtask

   task automatic send_next();
      task_t t;
      int n;
      t = stim[next_stim];
      next_stim++;
      overflow_task = t;
      overflow_valid = 1'b1;
      n = 0;
      while (!overflow_ready) tick(n, "overflow_ready stayed low");
      exp_out.push_back(t);  // accepted at the coming rising edge
      group[group_n] = t;
      group_n++;
      if (group_n == TASKS_PER_CHUNK) begin
         exp_child.push_back(chunk_min(group, group_n));
         group_n = 0;
      end
      @(negedge clk);
      overflow_valid = 1'b0;
   endtask

   // partial chunk padded by the coalescer
   task automatic flush_group();
      if (group_n != 0) exp_child.push_back(chunk_min(group, group_n));
      group_n = 0;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_out.size() != 0 || exp_child.size() != 0 || !split_ready) begin
         tick(n, {"tasks still outstanding in ", test_name});
      end
   endtask

   task automatic check_out(input task_t t);
      task_t e;
      assert (exp_out.size() != 0) else begin
         $display("ERROR in %s: out_task %h arrived with no task outstanding", test_name, t);
         note_error();
      end
      if (exp_out.size() != 0) begin
         e = exp_out.pop_front();
         checks++;
         assert (t == e) else report_value("out_task", 64'(e), 64'(t));
      end
   endtask

   task automatic take_child(input task_t c);
      ts_t e;
      checks++;
      assert (c.ttype == TTYPE_SPLITTER) else begin
         report_value("child ttype", 64'(TTYPE_SPLITTER), 64'(c.ttype));
      end
      assert (c.object < 16'(NUM_CHUNKS)) else begin
         $display("ERROR in %s: child object %0d is not a chunk id", test_name, c.object);
         note_error();
      end
      assert (exp_child.size() != 0) else begin
         $display("ERROR in %s: child task arrived with no chunk expected", test_name);
         note_error();
      end
      if (exp_child.size() != 0) begin
         e = exp_child.pop_front();
         assert (c.ts == e) else report_value("child ts", 64'(e), 64'(c.ts));
      end
      held.push_back(c);
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errs = 0;
      group_n = 0;
   endtask

   task automatic end_test();
      tests_run++;
      if (test_errs == 0) begin
         $display("test %s: passed", test_name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", test_name, test_errs);
      end
   endtask

   // loop-back and output side decide on the falling edge
   initial begin
      logic [31:0] r;
      logic split_taken;
      child_ready = 1'b0;
      split_valid = 1'b0;
      split_task = '0;
      out_ready = 1'b0;
      split_taken = 1'b0;
      forever begin
         @(negedge clk);
         r = $random(seed);
         out_ready = rstn && !(stall_out && r[1:0] == 2'b00);
         if (out_valid && out_ready) check_out(out_task);
         child_ready = rstn && !child_block && !(stall_child && r[3:2] == 2'b00);
         if (child_valid && child_ready) take_child(child_task);
         if (split_taken) begin
            split_valid = 1'b0;
            split_taken = 1'b0;
         end
         if (!split_valid && held.size() != 0 && !hold_children &&
             !(stall_split && r[5:4] == 2'b00)) begin
            split_task = held.pop_front();
            split_valid = 1'b1;
         end
         split_taken = split_valid && split_ready;  // taken at the next rising edge
      end
   end

   initial begin
      int n;
      logic [31:0] r;
      ts_t lvt_exp;
      seed = 32'h675f6c05;
      rstn = 1'b0;
      overflow_valid = 1'b0;
      overflow_task = '0;
      hold_children = 1'b0;
      child_block = 1'b0;
      stall_child = 1'b0;
      stall_split = 1'b0;
      stall_out = 1'b0;
      next_stim = 0;
      group_n = 0;
      errors = 0;
      checks = 0;
      tests_run = 0;
      tests_failed = 0;
      test_name = "reset";
      test_errs = 0;
      for (int i = 0; i < NUM_STIM; i++) begin
         r = $random(seed);
         stim[i].ts = r;
         r = $random(seed);
         stim[i].object = r[15:0];
         stim[i].ttype = r[19:16];
      end
      repeat (5) @(negedge clk);
      rstn = 1'b1;

      start_test("order");
      repeat (12) send_next();  // three full chunks
      wait_drain();
      end_test();

      start_test("child_ts");
      stall_child = 1'b1;
      repeat (8) send_next();
      wait_drain();
      stall_child = 1'b0;
      end_test();

      start_test("partial_chunk");
      repeat (2) send_next();
      flush_group();
      wait_drain();
      end_test();

      start_test("chunk_ids");
      hold_children = 1'b1;
      repeat (40) send_next();  // 8 chunks held plus a full spill FIFO
      n = 0;
      while (held.size() < NUM_CHUNKS) tick(n, "fewer than 8 children held");
      n = 0;
      while (overflow_ready) tick(n, "overflow_ready did not fall with no free chunk");
      for (int i = 0; i < held.size(); i++) begin
         for (int j = i + 1; j < held.size(); j++) begin
            checks++;
            assert (held[i].object != held[j].object) else begin
               $display("ERROR in %s: chunk id %0d held by two children",
                        test_name, held[i].object);
               note_error();
            end
         end
      end
      hold_children = 1'b0;
      wait_drain();
      end_test();

      start_test("lvt");
      n = 0;
      while (lvt != '1) tick(n, "lvt not all ones before the test");
      child_block = 1'b1;
      lvt_exp = '1;
      for (int i = 0; i < 8; i++) begin
         if (stim[next_stim].ts < lvt_exp) lvt_exp = stim[next_stim].ts;
         send_next();
      end
      checks++;
      assert (lvt == lvt_exp) else report_value("lvt", 64'(lvt_exp), 64'(lvt));
      n = 0;
      while (!child_valid) tick(n, "no child task while child_ready was low");
      checks++;
      assert (lvt == lvt_exp) else report_value("lvt", 64'(lvt_exp), 64'(lvt));
      child_block = 1'b0;
      wait_drain();
      n = 0;
      while (lvt != '1) tick(n, "lvt did not return to all ones after the drain");
      end_test();

      start_test("back_pressure");
      stall_out = 1'b1;
      stall_split = 1'b1;
      stall_child = 1'b1;
      repeat (20) send_next();
      wait_drain();
      stall_out = 1'b0;
      stall_split = 1'b0;
      stall_child = 1'b0;
      end_test();

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== spill_unit.f ====
hdl/spill_pkg.sv
hdl/sync_fifo.sv
hdl/coalescer.sv
hdl/splitter.sv
hdl/mem_arbiter.sv
hdl/spill_mem.sv
hdl/spill_top.sv
tb/tb_spill_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_spill_top
RTL_TOP    := spill_top
FILELIST   := spill_unit.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation finished: PASS
SOURCES    := $(wildcard hdl/*.sv tb/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
